// File: hdl/rs_pkg.sv
`default_nettype none

package rs_pkg;

  localparam int WORD_W   = 32;
  localparam int NUM_REGS = 16;
  localparam int REG_W    = $clog2(NUM_REGS);
  localparam int SLOTS    = 4;
  localparam int SLOT_W   = $clog2(SLOTS);

  typedef enum logic [2:0] {
    OP_LW   = 3'd0,
    OP_SW   = 3'd1,
    OP_ADD  = 3'd2,
    OP_MUL  = 3'd3,
    OP_MV   = 3'd4,
    OP_HALT = 3'd5
  } op_e;

  typedef enum logic {
    UNIT_ADD = 1'b0,
    UNIT_MUL = 1'b1
  } unit_e;

  typedef struct packed {
    logic              pending;  // low: register holds its own value
    unit_e             unit;
    logic [SLOT_W-1:0] slot;
  } tag_t;

  typedef struct packed {
    logic              ready;
    tag_t              tag;
    logic [WORD_W-1:0] value;
  } operand_t;

  typedef struct packed {
    logic              valid;
    unit_e             unit;
    logic [SLOT_W-1:0] slot;
    operand_t          a;
    operand_t          b;
  } dispatch_t;

  typedef struct packed {
    logic              valid;
    tag_t              tag;
    logic [WORD_W-1:0] value;
  } cdb_t;

  // operand picks up the bus value when it waits on that tag
  function automatic operand_t catch_bus(operand_t opnd, cdb_t bus);
    operand_t res;
    res = opnd;
    if (!opnd.ready && bus.valid && opnd.tag == bus.tag) begin
      res.ready = 1'b1;
      res.value = bus.value;
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: hdl/reg_status.sv
`default_nettype none

module reg_status import rs_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  input  wire logic                     rename_en,
  input  wire logic [REG_W-1:0]         rename_reg,
  input  wire tag_t                     rename_tag,
  input  wire logic                     imm_en,
  input  wire logic [REG_W-1:0]         imm_reg,
  input  wire logic signed [WORD_W-1:0] imm_value,
  input  wire cdb_t                     cdb,
  input  wire logic [REG_W-1:0]         look_a_reg,
  input  wire logic [REG_W-1:0]         look_b_reg,
  input  wire logic [REG_W-1:0]         reg_sel,
  output operand_t                      look_a,
  output operand_t                      look_b,
  output tag_t                          reg_tag,
  output logic signed [WORD_W-1:0]      reg_value
);

  logic [WORD_W-1:0] values [NUM_REGS];
  tag_t              tags   [NUM_REGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        values[i] <= '0;
        tags[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_REGS; i++) begin
        if (rename_en && rename_reg == REG_W'(i)) begin
          tags[i] <= rename_tag;  // new producer wins over a bus write
        end else if (imm_en && imm_reg == REG_W'(i)) begin
          tags[i]   <= '0;
          values[i] <= imm_value;
        end else if (cdb.valid && tags[i] == cdb.tag) begin
          tags[i]   <= '0;
          values[i] <= cdb.value;
        end
      end
    end
  end

  assign look_a = '{ready: !tags[look_a_reg].pending, tag: tags[look_a_reg],
                    value: values[look_a_reg]};
  assign look_b = '{ready: !tags[look_b_reg].pending, tag: tags[look_b_reg],
                    value: values[look_b_reg]};

  assign reg_tag   = tags[reg_sel];
  assign reg_value = values[reg_sel];

  // issue decode sends at most one write request per strobe
  one_write: assert property (@(posedge clk) disable iff (!arst_n)
    !(rename_en && imm_en));

endmodule

`default_nettype wire

// File: hdl/issue_ctrl.sv
`default_nettype none

module issue_ctrl import rs_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  input  wire logic                     enable,
  input  wire op_e                      op,
  input  wire logic [REG_W-1:0]         rd,
  input  wire logic [REG_W-1:0]         rs1,
  input  wire logic [REG_W-1:0]         rs2,
  input  wire logic                     has_imm,
  input  wire logic signed [WORD_W-1:0] imm,
  input  wire operand_t                 look_a,
  input  wire operand_t                 look_b,
  input  wire cdb_t                     cdb,
  input  wire logic [SLOTS-1:0]         add_free,
  input  wire logic [SLOTS-1:0]         mul_free,
  output logic [REG_W-1:0]              look_a_reg,
  output logic [REG_W-1:0]              look_b_reg,
  output dispatch_t                     dispatch,
  output logic                          rename_en,
  output logic [REG_W-1:0]              rename_reg,
  output tag_t                          rename_tag,
  output logic                          imm_en,
  output logic [REG_W-1:0]              imm_reg,
  output logic signed [WORD_W-1:0]      imm_value,
  output logic                          issue_ok
);

  unit_e             target;
  logic              to_bank;  // add, mul or register mv
  logic              imm_mv;
  logic [SLOTS-1:0]  free_vec;
  logic              found;
  logic [SLOT_W-1:0] slot;
  operand_t          opnd_a;
  operand_t          opnd_b;
  logic              take;

  assign look_a_reg = rs1;
  assign look_b_reg = rs2;

  always_comb begin
    target  = UNIT_ADD;
    to_bank = 1'b0;
    imm_mv  = 1'b0;
    case (op)
      OP_ADD: to_bank = 1'b1;
      OP_MUL: begin
        target  = UNIT_MUL;
        to_bank = 1'b1;
      end
      OP_MV: begin
        to_bank = !has_imm;  // register mv runs as add of zero
        imm_mv  = has_imm;
      end
      default: ;  // lw, sw, halt refused
    endcase
  end

  assign free_vec = (target == UNIT_MUL) ? mul_free : add_free;

  // lowest free slot
  always_comb begin
    found = 1'b0;
    slot  = '0;
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (free_vec[i]) begin
        found = 1'b1;
        slot  = SLOT_W'(i);
      end
    end
  end

  always_comb begin
    opnd_a = catch_bus(look_a, cdb);
    if (op == OP_MV) begin
      opnd_b = '{ready: 1'b1, tag: '0, value: '0};
    end else if (has_imm) begin
      opnd_b = '{ready: 1'b1, tag: '0, value: imm};
    end else begin
      opnd_b = catch_bus(look_b, cdb);
    end
  end

  assign take     = enable && to_bank && found;
  assign dispatch = '{valid: take, unit: target, slot: slot, a: opnd_a, b: opnd_b};

  assign rename_en  = take;
  assign rename_reg = rd;
  assign rename_tag = '{pending: 1'b1, unit: target, slot: slot};

  assign imm_en    = enable && imm_mv;
  assign imm_reg   = rd;
  assign imm_value = imm;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_ok <= 1'b0;
    end else if (enable) begin
      issue_ok <= take || imm_mv;
    end
  end

endmodule

`default_nettype wire

// File: hdl/station_bank.sv
`default_nettype none

module station_bank import rs_pkg::*; #(
  parameter unit_e KIND = UNIT_ADD
) (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  input  wire dispatch_t                dispatch,
  input  wire cdb_t                     cdb,
  input  wire logic [SLOTS-1:0]         grant,
  output logic [SLOTS-1:0]              free,
  output logic [SLOTS-1:0]              ready,
  output logic [SLOTS-1:0][WORD_W-1:0]  result,
  output logic                          empty
);

  logic [SLOTS-1:0] busy;
  logic [SLOTS-1:0] load;
  operand_t         op_a [SLOTS];
  operand_t         op_b [SLOTS];

  for (genvar i = 0; i < SLOTS; i++) begin : g_slot
    assign load[i]  = dispatch.valid && dispatch.unit == KIND &&
                      dispatch.slot == SLOT_W'(i);
    assign ready[i] = busy[i] && op_a[i].ready && op_b[i].ready;

    if (KIND == UNIT_ADD) begin : g_add
      assign result[i] = $signed(op_a[i].value) + $signed(op_b[i].value);
    end else begin : g_mul
      // low word of the signed product
      assign result[i] = $signed(op_a[i].value) * $signed(op_b[i].value);
    end
  end

  assign free  = ~busy;
  assign empty = ~|busy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= '0;
    end else begin
      busy <= (busy & ~grant) | load;  // granted slot frees at the broadcast edge
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < SLOTS; i++) begin
      if (load[i]) begin
        op_a[i] <= dispatch.a;
        op_b[i] <= dispatch.b;
      end else if (busy[i]) begin
        op_a[i] <= catch_bus(op_a[i], cdb);
        op_b[i] <= catch_bus(op_b[i], cdb);
      end
    end
  end

  grant_ready: assert property (@(posedge clk) disable iff (!arst_n)
    (grant & ~ready) == '0);

  load_free: assert property (@(posedge clk) disable iff (!arst_n)
    (load & busy) == '0);

endmodule

`default_nettype wire

// File: hdl/cdb_arbiter.sv
`default_nettype none

module cdb_arbiter import rs_pkg::*; (
  input  wire logic [SLOTS-1:0]             add_ready,
  input  wire logic [SLOTS-1:0]             mul_ready,
  input  wire logic [SLOTS-1:0][WORD_W-1:0] add_result,
  input  wire logic [SLOTS-1:0][WORD_W-1:0] mul_result,
  output logic [SLOTS-1:0]                  add_grant,
  output logic [SLOTS-1:0]                  mul_grant,
  output cdb_t                              cdb
);

  // add bank first, then mul, lowest slot first
  always_comb begin
    logic found;
    found     = 1'b0;
    add_grant = '0;
    mul_grant = '0;
    cdb       = '0;
    for (int i = 0; i < SLOTS; i++) begin
      if (!found && add_ready[i]) begin
        found        = 1'b1;
        add_grant[i] = 1'b1;
        cdb = '{valid: 1'b1, tag: '{pending: 1'b1, unit: UNIT_ADD, slot: SLOT_W'(i)},
                value: add_result[i]};
      end
    end
    for (int i = 0; i < SLOTS; i++) begin
      if (!found && mul_ready[i]) begin
        found        = 1'b1;
        mul_grant[i] = 1'b1;
        cdb = '{valid: 1'b1, tag: '{pending: 1'b1, unit: UNIT_MUL, slot: SLOT_W'(i)},
                value: mul_result[i]};
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rs_core.sv
`default_nettype none

module rs_core import rs_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  input  wire logic                     enable,
  input  wire op_e                      op,
  input  wire logic [REG_W-1:0]         rd,
  input  wire logic [REG_W-1:0]         rs1,
  input  wire logic [REG_W-1:0]         rs2,
  input  wire logic                     has_imm,
  input  wire logic signed [WORD_W-1:0] imm,
  input  wire logic [REG_W-1:0]         reg_sel,
  output logic                          issue_ok,
  output logic                          idle,
  output tag_t                          reg_tag,
  output logic signed [WORD_W-1:0]      reg_value
);

  operand_t                   look_a;
  operand_t                   look_b;
  logic [REG_W-1:0]           look_a_reg;
  logic [REG_W-1:0]           look_b_reg;
  dispatch_t                  dispatch;
  logic                       rename_en;
  logic [REG_W-1:0]           rename_reg;
  tag_t                       rename_tag;
  logic                       imm_en;
  logic [REG_W-1:0]           imm_reg;
  logic signed [WORD_W-1:0]   imm_value;
  cdb_t                       cdb;
  logic [SLOTS-1:0]           add_free, mul_free;
  logic [SLOTS-1:0]           add_ready, mul_ready;
  logic [SLOTS-1:0]           add_grant, mul_grant;
  logic [SLOTS-1:0][WORD_W-1:0] add_result, mul_result;
  logic                       add_empty, mul_empty;

  reg_status reg_status_inst (.*);

  issue_ctrl issue_ctrl_inst (.*);

  station_bank #(.KIND(UNIT_ADD)) add_bank_inst (
    .clk(clk), .arst_n(arst_n), .dispatch(dispatch), .cdb(cdb), .grant(add_grant),
    .free(add_free), .ready(add_ready), .result(add_result), .empty(add_empty)
  );

  station_bank #(.KIND(UNIT_MUL)) mul_bank_inst (
    .clk(clk), .arst_n(arst_n), .dispatch(dispatch), .cdb(cdb), .grant(mul_grant),
    .free(mul_free), .ready(mul_ready), .result(mul_result), .empty(mul_empty)
  );

  cdb_arbiter cdb_arbiter_inst (.*);

  assign idle = add_empty && mul_empty;  // nothing left in flight

endmodule

`default_nettype wire

// File: bench/rs_checker.sv
`default_nettype none

module rs_checker import rs_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     arst_n,
  input  wire logic                     enable,
  input  wire op_e                      op,
  input  wire logic [REG_W-1:0]         rd,
  input  wire logic [REG_W-1:0]         rs1,
  input  wire logic [REG_W-1:0]         rs2,
  input  wire logic                     has_imm,
  input  wire logic signed [WORD_W-1:0] imm,
  input  wire logic [REG_W-1:0]         reg_sel,
  input  wire logic                     issue_ok,
  input  wire logic                     idle,
  input  wire tag_t                     reg_tag,
  input  wire logic signed [WORD_W-1:0] reg_value,
  input  wire logic                     sweep,
  output int                            errors
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    op_e               op;
    logic [REG_W-1:0]  rd;
    logic [REG_W-1:0]  rs1;
    logic [REG_W-1:0]  rs2;
    logic              has_imm;
    logic [WORD_W-1:0] imm;
  } instr_t;

  instr_t            last;
  logic              strobed;
  logic              reset_seen;
  logic [WORD_W-1:0] model [NUM_REGS];  // in-order register file

  // result of one instruction from in-order operand values
  function automatic logic [WORD_W-1:0] expected_result(instr_t ins, logic [WORD_W-1:0] a,
                                                        logic [WORD_W-1:0] b);
    logic [WORD_W-1:0] rhs;
    rhs = ins.has_imm ? ins.imm : b;
    case (ins.op)
      OP_ADD:  return a + rhs;
      OP_MUL:  return a * rhs;  // low word only
      default: return ins.has_imm ? ins.imm : a;
    endcase
  endfunction

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      strobed <= 1'b0;
    end else begin
      strobed <= enable;
      last    <= '{op: op, rd: rd, rs1: rs1, rs2: rs2, has_imm: has_imm, imm: imm};
    end
  end

  always @(negedge clk) begin
    if (!arst_n) begin
      reset_seen = 1'b0;
      for (int i = 0; i < NUM_REGS; i++) begin
        model[i] = '0;
      end
    end else begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (issue_ok !== 1'b0 || idle !== 1'b1) begin
          errors++;
          $display("FAILED reset_state: expected issue_ok=0 idle=1, actual issue_ok=%b idle=%b",
                   issue_ok, idle);
        end
      end
      if (strobed) begin
        if (!(last.op inside {OP_ADD, OP_MUL, OP_MV})) begin
          if (issue_ok !== 1'b0) begin
            errors++;
            $display("FAILED refuse_op %s: expected issue_ok 0, actual %b",
                     last.op.name(), issue_ok);
          end
        end else if (issue_ok === 1'b1) begin
          model[last.rd] = expected_result(last, model[last.rs1], model[last.rs2]);
        end else if (last.op == OP_MV && last.has_imm) begin
          errors++;  // needs no station, so it cannot be refused
          $display("FAILED imm_mv: expected issue_ok 1, actual %b", issue_ok);
        end
      end
      if (sweep) begin
        if (reg_value !== model[reg_sel] || reg_tag.pending !== 1'b0) begin
          errors++;
          $display("FAILED reg_sweep r%0d: expected %h pending 0, actual %h pending %b",
                   reg_sel, model[reg_sel], reg_value, reg_tag.pending);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: bench/rs_core_tb.sv
`default_nettype none

module rs_core_tb import rs_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_INSTR = 200;
  localparam int PERIOD    = 4;
  localparam int LIMIT     = NUM_INSTR * (2 * SLOTS + 6) * PERIOD;

  logic                     clk = 1'b0;
  logic                     arst_n;
  logic                     enable;
  op_e                      op;
  logic [REG_W-1:0]         rd;
  logic [REG_W-1:0]         rs1;
  logic [REG_W-1:0]         rs2;
  logic                     has_imm;
  logic signed [WORD_W-1:0] imm;
  logic [REG_W-1:0]         reg_sel;
  logic                     issue_ok;
  logic                     idle;
  tag_t                     reg_tag;
  logic signed [WORD_W-1:0] reg_value;
  logic                     sweep;
  int                       errors;
  int                       skipped;
  int                       seed = 32'h0c527995;

  always #(PERIOD / 2) clk = ~clk;

  rs_core rs_core_inst (.*);

  rs_checker rs_checker_inst (.*);

  // strobe once per try; a full bank sends the same instruction again
  task automatic issue_instr(input op_e o, input logic [REG_W-1:0] d, s1, s2,
                             input logic imm_sel, input logic [WORD_W-1:0] value);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      enable  <= 1'b1;
      op      <= o;
      rd      <= d;
      rs1     <= s1;
      rs2     <= s2;
      has_imm <= imm_sel;
      imm     <= value;
      @(posedge clk);
      enable <= 1'b0;
      @(negedge clk);
      if (issue_ok) begin
        done = 1'b1;
      end else if (!(o inside {OP_ADD, OP_MUL, OP_MV})) begin
        skipped++;  // lw, sw, halt are never accepted
        done = 1'b1;
      end
    end
  endtask

  task automatic random_instr();
    int               pick;
    op_e              o;
    logic [REG_W-1:0] d;
    logic [REG_W-1:0] s1;
    logic [REG_W-1:0] s2;
    logic             imm_sel;
    pick    = {$random(seed)} % 16;
    d       = REG_W'($random(seed));
    s1      = REG_W'($random(seed));
    s2      = REG_W'($random(seed));
    imm_sel = 1'($random(seed));
    case (pick)
      0: o = OP_LW;
      1: o = OP_SW;
      2: o = OP_HALT;
      3, 4, 5, 6, 7: o = OP_ADD;
      8, 9, 10, 11: o = OP_MUL;
      default: o = OP_MV;
    endcase
    issue_instr(o, d, s1, s2, imm_sel, $random(seed) % 64);
  endtask

  task automatic wait_idle();
    while (!idle) @(negedge clk);
  endtask

  // checker compares each register while sweep is high
  task automatic sweep_regs();
    for (int i = 0; i < NUM_REGS; i++) begin
      @(posedge clk);
      sweep   <= 1'b1;
      reg_sel <= REG_W'(i);
    end
    @(posedge clk);
    sweep <= 1'b0;
  endtask

  initial begin
    arst_n  = 1'b0;
    enable  = 1'b0;
    op      = OP_ADD;
    rd      = '0;
    rs1     = '0;
    rs2     = '0;
    has_imm = 1'b0;
    imm     = '0;
    reg_sel = '0;
    sweep   = 1'b0;
    skipped = 0;
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;
    sweep_regs();  // all zero, nothing pending
    for (int i = 0; i < NUM_REGS; i++) begin
      issue_instr(OP_MV, REG_W'(i), '0, '0, 1'b1, i * 5 - 30);
    end
    wait_idle();
    sweep_regs();
    for (int n = 0; n < NUM_INSTR; n++) begin
      random_instr();
    end
    wait_idle();
    sweep_regs();
    $display("errors=%0d refused_lw_sw_halt=%0d", errors, skipped);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT);
    $display("timeout after %0d ns, the core never drained", LIMIT);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: rs_core.f
hdl/rs_pkg.sv
hdl/reg_status.sv
hdl/issue_ctrl.sv
hdl/station_bank.sv
hdl/cdb_arbiter.sv
hdl/rs_core.sv
bench/rs_checker.sv
bench/rs_core_tb.sv
